// ==== board/board_locator.sv ====
module board_locator (
    input  logic                  vga_clk,
    input  logic                  rst_n,
    input  ppu_pkg::coord_t       x,
    input  ppu_pkg::coord_t       y,
    output logic                  in_board,
    output logic                  in_grid,
    output logic                  board_sel,
    output ppu_pkg::square_idx_t  square,
    output logic                  on_line
);

    localparam ppu_pkg::coord_t grid_span =
        ppu_pkg::coord_t'(ppu_pkg::grid_squares) * ppu_pkg::square_size;

    ppu_pkg::coord_t dx0;
    ppu_pkg::coord_t dx1;
    ppu_pkg::coord_t dy;
    ppu_pkg::coord_t gx;
    ppu_pkg::coord_t gy;
    logic hit0;
    logic hit1;
    logic board_hit;
    logic grid_hit;
    ppu_pkg::square_idx_t row;
    ppu_pkg::square_idx_t col;
    ppu_pkg::square_idx_t square_next;

    // offsets wrap left of and above a board, so one compare bounds both sides
    assign dx0 = x - ppu_pkg::board0_x;
    assign dx1 = x - ppu_pkg::board1_x;
    assign dy  = y - ppu_pkg::board_y;

    assign hit0      = dx0 < ppu_pkg::board_size;
    assign hit1      = dx1 < ppu_pkg::board_size;
    assign board_hit = (dy < ppu_pkg::board_size) && (hit0 || hit1);

    assign gx       = (hit1 ? dx1 : dx0) - ppu_pkg::grid_margin;
    assign gy       = dy - ppu_pkg::grid_margin;
    assign grid_hit = board_hit && (gx < grid_span) && (gy < grid_span);

    // 16 pixel squares, so the square position is offset bits 7:4
    assign row         = {3'b000, gy[7:4]};
    assign col         = {3'b000, gx[7:4]};
    assign square_next = grid_hit ? row * ppu_pkg::grid_squares + col : '0;

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            in_board  <= 1'b0;
            in_grid   <= 1'b0;
            board_sel <= 1'b0;
            square    <= '0;
            on_line   <= 1'b0;
        end else begin
            in_board  <= board_hit;
            in_grid   <= grid_hit;
            board_sel <= hit1;
            square    <= square_next;
            on_line   <= (gx[3:0] == 4'd0) || (gy[3:0] == 4'd0);
        end
    end

    a_square_range: assert property (@(posedge vga_clk) disable iff (!rst_n)
        in_grid |-> square < ppu_pkg::grid_squares * ppu_pkg::grid_squares);

endmodule

// ==== board/board_renderer.sv ====
module board_renderer (
    input  logic                  vga_clk,
    input  logic                  rst_n,
    input  ppu_pkg::coord_t       x,
    input  ppu_pkg::coord_t       y,
    input  logic                  vblank,
    input  logic                  update_valid,
    input  logic                  update_board,
    input  ppu_pkg::square_idx_t  update_square,
    input  ppu_pkg::square_rec_t  update_rec,
    output logic                  update_ready,
    output logic                  board_hit,
    output ppu_pkg::pixel_t       board_pixel
);

    logic in_board;
    logic in_grid;
    logic board_sel;
    logic on_line;
    ppu_pkg::square_idx_t square;
    ppu_pkg::square_rec_t rec;

    // locator flags delayed one more cycle to line up with the store read
    logic in_board_q;
    logic in_grid_q;
    logic board_q;
    logic on_line_q;

    ppu_pkg::square_state_t state;
    ppu_pkg::pixel_t        fill;

    board_locator u_locator (
        .vga_clk   (vga_clk),
        .rst_n     (rst_n),
        .x         (x),
        .y         (y),
        .in_board  (in_board),
        .in_grid   (in_grid),
        .board_sel (board_sel),
        .square    (square),
        .on_line   (on_line)
    );

    square_store u_store (
        .vga_clk       (vga_clk),
        .rst_n         (rst_n),
        .vblank        (vblank),
        .update_valid  (update_valid),
        .update_board  (update_board),
        .update_square (update_square),
        .update_rec    (update_rec),
        .rd_board      (board_sel),
        .rd_square     (square),
        .update_ready  (update_ready),
        .rd_rec        (rec)
    );

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            in_board_q <= 1'b0;
            in_grid_q  <= 1'b0;
            board_q    <= 1'b0;
            on_line_q  <= 1'b0;
        end else begin
            in_board_q <= in_board;
            in_grid_q  <= in_grid;
            board_q    <= board_sel;
            on_line_q  <= on_line;
        end
    end

    assign state = ppu_pkg::square_state_t'(rec[5:4]);

    always_comb begin
        case (state)
            ppu_pkg::st_miss: fill = board_q ? ppu_pkg::col_miss_enemy : ppu_pkg::col_miss_player;
            ppu_pkg::st_hit:  fill = board_q ? ppu_pkg::col_hit_enemy : ppu_pkg::col_hit_player;
            ppu_pkg::st_ship: fill = ppu_pkg::col_ship[rec[3:2]];
            default:          fill = ppu_pkg::col_empty;
        endcase
        // ai marker, then selection inverts whatever is there
        if (rec[0]) begin
            fill = ppu_pkg::col_ai;
        end
        if (rec[1]) begin
            fill = ~fill;
        end
    end

    // frame and grid lines are never marked
    assign board_pixel = !in_grid_q ? ppu_pkg::col_frame :
                         on_line_q  ? ppu_pkg::col_grid  : fill;
    assign board_hit   = in_board_q;

endmodule

// ==== board/square_store.sv ====
module square_store (
    input  logic                  vga_clk,
    input  logic                  rst_n,
    input  logic                  vblank,
    input  logic                  update_valid,
    input  logic                  update_board,
    input  ppu_pkg::square_idx_t  update_square,
    input  ppu_pkg::square_rec_t  update_rec,
    input  logic                  rd_board,
    input  ppu_pkg::square_idx_t  rd_square,
    output logic                  update_ready,
    output ppu_pkg::square_rec_t  rd_rec
);

    ppu_pkg::square_rec_t mem [0:1][0:99];
    logic wr_en;

    // only accept while the raster is off screen, so no frame tears
    assign update_ready = vblank;
    assign wr_en        = update_valid && update_ready;

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < 2; b++) begin
                for (int s = 0; s < 100; s++) begin
                    mem[b][s] <= '0;
                end
            end
        end else if (wr_en) begin
            mem[update_board][update_square] <= update_rec;
        end
    end

    // registered read for the board pipeline
    always_ff @(posedge vga_clk) begin
        rd_rec <= mem[rd_board][rd_square];
    end

    // outside vblank the record at the update address keeps its value
    a_write_in_vblank: assert property (@(posedge vga_clk) disable iff (!rst_n)
        (!vblank && update_square < ppu_pkg::grid_squares * ppu_pkg::grid_squares) |=>
            mem[$past(update_board)][$past(update_square)] ==
            $past(mem[update_board][update_square]));

    a_write_in_range: assert property (@(posedge vga_clk) disable iff (!rst_n)
        wr_en |-> update_square < ppu_pkg::grid_squares * ppu_pkg::grid_squares);

endmodule

// ==== common/ppu_pkg.sv ====
package ppu_pkg;

    typedef logic [9:0] coord_t;
    typedef logic [7:0] pixel_t;
    typedef logic [6:0] square_idx_t;
    typedef logic [1:0] ship_type_t;

    // record layout from the top: state, ship type, sel, ai
    typedef logic [5:0] square_rec_t;

    typedef enum logic [1:0] {
        st_empty,
        st_miss,
        st_hit,
        st_ship
    } square_state_t;

    // 640x480 at 60 Hz
    localparam coord_t h_active     = 10'd640;
    localparam coord_t v_active     = 10'd480;
    localparam coord_t h_total      = 10'd800;
    localparam coord_t v_total      = 10'd525;
    localparam coord_t h_sync_start = 10'd656;
    localparam coord_t h_sync_end   = 10'd752;
    localparam coord_t v_sync_start = 10'd490;
    localparam coord_t v_sync_end   = 10'd492;

    // label margin of 23 plus the 173 pixel board
    localparam coord_t board0_x    = 10'd83;
    localparam coord_t board1_x    = 10'd361;
    localparam coord_t board_y     = 10'd170;
    localparam coord_t board_size  = 10'd196;
    localparam coord_t grid_margin = 10'd29;
    localparam coord_t square_size = 10'd16;
    localparam square_idx_t grid_squares = 7'd10;

    localparam coord_t title_x = 10'd160;
    localparam coord_t title_y = 10'd16;
    localparam coord_t title_w = 10'd321;
    localparam coord_t title_h = 10'd64;
    localparam coord_t turn_x  = 10'd170;
    localparam coord_t turn_y  = 10'd94;
    localparam coord_t turn_w  = 10'd300;
    localparam coord_t turn_h  = 10'd36;
    localparam coord_t shore_y = 10'd416;

    // RGB332 palette
    localparam pixel_t col_water       = 8'h13;
    localparam pixel_t col_shore       = 8'hD5;
    localparam pixel_t col_title       = 8'hFC;
    localparam pixel_t col_turn_yours  = 8'h1C;
    localparam pixel_t col_turn_wait   = 8'hE0;
    localparam pixel_t col_frame       = 8'h49;
    localparam pixel_t col_grid        = 8'h00;
    localparam pixel_t col_empty       = 8'h0B;
    localparam pixel_t col_ai          = 8'h1C;
    localparam pixel_t col_miss_player = 8'hB6;
    localparam pixel_t col_miss_enemy  = 8'h92;
    localparam pixel_t col_hit_player  = 8'hE4;
    localparam pixel_t col_hit_enemy   = 8'hE0;
    localparam pixel_t col_ship [4]    = '{8'h6D, 8'h92, 8'hAD, 8'hB2};

    // raster coordinate to colour at the pins
    localparam int pipe_depth = 3;

endpackage

// ==== dv/ppu_tb.sv ====
module ppu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int h_tot       = int'(ppu_pkg::h_total);
    localparam int v_tot       = int'(ppu_pkg::v_total);
    localparam int frame       = h_tot * v_tot;
    localparam int run_cycles  = 3 * frame + 8 * h_tot;
    localparam int cycle_limit = 4 * frame + 1000;
    localparam int b0x         = int'(ppu_pkg::board0_x);
    localparam int b1x         = int'(ppu_pkg::board1_x);
    localparam int by          = int'(ppu_pkg::board_y);
    localparam int bsize       = int'(ppu_pkg::board_size);
    localparam int margin      = int'(ppu_pkg::grid_margin);

    logic       vga_clk;
    logic       rst_n;
    logic       update_valid;
    logic       update_board;
    logic [6:0] update_square;
    logic [5:0] update_rec;
    logic       turn;
    logic       update_ready;
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    logic       hsync;
    logic       vsync;
    logic       blank_n;

    // testbench model state
    logic [31:0] lfsr_state;
    logic [5:0]  mirror [0:1][0:99];
    logic        turn_m;
    logic        accepted;
    int          cycle_count = 0;

    ppu_top u_dut (
        .vga_clk       (vga_clk),
        .rst_n         (rst_n),
        .update_valid  (update_valid),
        .update_board  (update_board),
        .update_square (update_square),
        .update_rec    (update_rec),
        .turn          (turn),
        .update_ready  (update_ready),
        .r             (r),
        .g             (g),
        .b             (b),
        .hsync         (hsync),
        .vsync         (vsync),
        .blank_n       (blank_n)
    );

    initial begin
        vga_clk = 1'b0;
        forever #5 vga_clk = ~vga_clk;
    end

    always @(posedge vga_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not end within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int x_at(input int p);
        return p % h_tot;
    endfunction

    function automatic int y_at(input int p);
        return (p / h_tot) % v_tot;
    endfunction

    function automatic logic vblank_at(input int p);
        return y_at(p) >= int'(ppu_pkg::v_active);
    endfunction

    function automatic logic [7:0] expected_colour(input int qx, input int qy);
        int bsel;
        int gx;
        int gy;
        logic [5:0] rec;
        logic [7:0] c;
        bsel = -1;
        if (qy >= by && qy < by + bsize) begin
            if (qx >= b0x && qx < b0x + bsize) begin
                bsel = 0;
            end else if (qx >= b1x && qx < b1x + bsize) begin
                bsel = 1;
            end
        end
        if (bsel >= 0) begin
            gx = qx - (bsel == 1 ? b1x : b0x) - margin;
            gy = qy - by - margin;
            if (gx < 0 || gx >= 160 || gy < 0 || gy >= 160) begin
                return ppu_pkg::col_frame;
            end
            if (gx % 16 == 0 || gy % 16 == 0) begin
                return ppu_pkg::col_grid;
            end
            rec = mirror[bsel][(gy / 16) * 10 + gx / 16];
            case (rec[5:4])
                ppu_pkg::st_miss: c = bsel ? ppu_pkg::col_miss_enemy : ppu_pkg::col_miss_player;
                ppu_pkg::st_hit:  c = bsel ? ppu_pkg::col_hit_enemy : ppu_pkg::col_hit_player;
                ppu_pkg::st_ship: c = ppu_pkg::col_ship[rec[3:2]];
                default:          c = ppu_pkg::col_empty;
            endcase
            if (rec[0]) begin
                c = ppu_pkg::col_ai;
            end
            if (rec[1]) begin
                c = ~c;
            end
            return c;
        end
        if (qy >= int'(ppu_pkg::shore_y)) begin
            return ppu_pkg::col_shore;
        end
        if (qx >= 160 && qx < 481 && qy >= 16 && qy < 80) begin
            return ppu_pkg::col_title;
        end
        if (qx >= 170 && qx < 470 && qy >= 94 && qy < 130) begin
            return turn_m ? ppu_pkg::col_turn_yours : ppu_pkg::col_turn_wait;
        end
        return ppu_pkg::col_water;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_outputs(input int p);
        int qx;
        int qy;
        logic act;
        logic [7:0] c;
        check_value("update_ready", update_ready, vblank_at(p));
        if (p < ppu_pkg::pipe_depth) begin
            // pipeline still holds reset values
            check_value("hsync", hsync, 1'b1);
            check_value("vsync", vsync, 1'b1);
            check_value("blank_n", blank_n, 1'b0);
            check_value("rgb", {r, g, b}, 24'h0);
        end else begin
            qx  = x_at(p - ppu_pkg::pipe_depth);
            qy  = y_at(p - ppu_pkg::pipe_depth);
            act = (qx < 640) && (qy < 480);
            c   = act ? expected_colour(qx, qy) : 8'h00;
            check_value("hsync", hsync, !(qx >= 656 && qx < 752));
            check_value("vsync", vsync, !(qy >= 490 && qy < 492));
            check_value("blank_n", blank_n, act);
            check_value("r", r, {c[7:5], 5'b00000});
            check_value("g", g, {c[4:2], 5'b00000});
            check_value("b", b, {c[1:0], 6'b000000});
        end
    endtask

    task automatic update_model(input int p);
        // write accepted and turn sampled on the edge just passed
        accepted = update_valid && vblank_at(p - 1);
        if (accepted) begin
            mirror[update_board][update_square] = update_rec;
        end
        if (p >= 2 && vblank_at(p - 1) && !vblank_at(p - 2)) begin
            turn_m = turn;
        end
    endtask

    task automatic new_write();
        logic [6:0] sq;
        logic [1:0] st;
        logic [1:0] ty;
        update_board = rand_bits(1);
        sq = rand_bits(7);
        if (sq >= 7'd100) begin
            sq = sq - 7'd100;
        end
        st = rand_bits(2);
        ty = rand_bits(2);
        update_square = sq;
        update_rec    = {st, ty, rand_bits(2) == 3, rand_bits(2) == 3};
        update_valid  = 1'b1;
    endtask

    task automatic drive_inputs(input int p);
        // a pending write stays on the port until it is taken
        if (!(update_valid && !accepted)) begin
            update_valid = 1'b0;
            if (vblank_at(p)) begin
                if (rand_bits(2) != 0) begin
                    new_write();
                end
            end else if (y_at(p) == 470 && x_at(p) == 0) begin
                new_write();
            end
        end
        // toggled while the turn band itself is on screen
        if (y_at(p) == 110 && x_at(p) == 320) begin
            turn = ~turn;
        end
    endtask

    initial begin
        int p;
        rst_n         = 1'b0;
        update_valid  = 1'b0;
        update_board  = 1'b0;
        update_square = '0;
        update_rec    = '0;
        turn          = 1'b0;
        lfsr_state    = 32'h2f0c_cd92;
        turn_m        = 1'b0;
        accepted      = 1'b0;
        for (int bd = 0; bd < 2; bd++) begin
            for (int s = 0; s < 100; s++) begin
                mirror[bd][s] = '0;
            end
        end
        repeat (4) @(negedge vga_clk);
        check_value("hsync", hsync, 1'b1);
        check_value("vsync", vsync, 1'b1);
        check_value("blank_n", blank_n, 1'b0);
        check_value("rgb", {r, g, b}, 24'h0);
        check_value("update_ready", update_ready, 1'b0);
        rst_n = 1'b1;
        for (p = 1; p <= run_cycles; p++) begin
            @(negedge vga_clk);
            update_model(p);
            check_outputs(p);
            drive_inputs(p);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== sim.f ====
common/ppu_pkg.sv
source/vga_timing.sv
board/square_store.sv
board/board_locator.sv
board/board_renderer.sv
source/backdrop_renderer.sv
source/pixel_mixer.sv
source/ppu_top.sv
dv/ppu_tb.sv

// ==== source/backdrop_renderer.sv ====
module backdrop_renderer (
    input  logic            vga_clk,
    input  logic            rst_n,
    input  ppu_pkg::coord_t x,
    input  ppu_pkg::coord_t y,
    input  logic            vblank,
    input  logic            turn,
    output ppu_pkg::pixel_t back_pixel
);

    logic shore_hit;
    logic title_hit;
    logic turn_hit;
    logic in_shore;
    logic in_title;
    logic in_turn;
    logic vblank_d;
    logic turn_latch;

    assign shore_hit = y >= ppu_pkg::shore_y;
    assign title_hit = (x >= ppu_pkg::title_x) && (x < ppu_pkg::title_x + ppu_pkg::title_w) &&
                       (y >= ppu_pkg::title_y) && (y < ppu_pkg::title_y + ppu_pkg::title_h);
    assign turn_hit  = (x >= ppu_pkg::turn_x) && (x < ppu_pkg::turn_x + ppu_pkg::turn_w) &&
                       (y >= ppu_pkg::turn_y) && (y < ppu_pkg::turn_y + ppu_pkg::turn_h);

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            in_shore   <= 1'b0;
            in_title   <= 1'b0;
            in_turn    <= 1'b0;
            vblank_d   <= 1'b0;
            turn_latch <= 1'b0;
        end else begin
            in_shore <= shore_hit;
            in_title <= title_hit;
            in_turn  <= turn_hit;
            vblank_d <= vblank;
            // sample once as vblank opens, shown from the next frame
            if (vblank && !vblank_d) begin
                turn_latch <= turn;
            end
        end
    end

    always_ff @(posedge vga_clk) begin
        if (in_shore) begin
            back_pixel <= ppu_pkg::col_shore;
        end else if (in_title) begin
            back_pixel <= ppu_pkg::col_title;
        end else if (in_turn) begin
            back_pixel <= turn_latch ? ppu_pkg::col_turn_yours : ppu_pkg::col_turn_wait;
        end else begin
            back_pixel <= ppu_pkg::col_water;
        end
    end

endmodule

// ==== source/pixel_mixer.sv ====
module pixel_mixer (
    input  logic            vga_clk,
    input  logic            rst_n,
    input  logic            board_hit,
    input  ppu_pkg::pixel_t board_pixel,
    input  ppu_pkg::pixel_t back_pixel,
    input  logic            active,
    input  logic            raw_hsync,
    input  logic            raw_vsync,
    output logic [7:0]      r,
    output logic [7:0]      g,
    output logic [7:0]      b,
    output logic            hsync,
    output logic            vsync,
    output logic            blank_n
);

    // the output register is the last stage
    localparam int stages = ppu_pkg::pipe_depth - 1;

    logic [stages-1:0] active_d;
    logic [stages-1:0] hsync_d;
    logic [stages-1:0] vsync_d;
    ppu_pkg::pixel_t   pix;

    assign pix = board_hit ? board_pixel : back_pixel;

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            active_d <= '0;
            hsync_d  <= '1;
            vsync_d  <= '1;
            hsync    <= 1'b1;
            vsync    <= 1'b1;
            blank_n  <= 1'b0;
            r        <= '0;
            g        <= '0;
            b        <= '0;
        end else begin
            active_d <= {active_d[stages-2:0], active};
            hsync_d  <= {hsync_d[stages-2:0], raw_hsync};
            vsync_d  <= {vsync_d[stages-2:0], raw_vsync};
            hsync    <= hsync_d[stages-1];
            vsync    <= vsync_d[stages-1];
            blank_n  <= active_d[stages-1];
            // RGB332 to 8 bits per channel, black outside the active area
            if (active_d[stages-1]) begin
                r <= {pix[7:5], 5'b00000};
                g <= {pix[4:2], 5'b00000};
                b <= {pix[1:0], 6'b000000};
            end else begin
                r <= '0;
                g <= '0;
                b <= '0;
            end
        end
    end

endmodule

// ==== source/ppu_top.sv ====
module ppu_top #(
    parameter ppu_pkg::coord_t h_total = ppu_pkg::h_total,
    parameter ppu_pkg::coord_t v_total = ppu_pkg::v_total
) (
    input  logic                  vga_clk,
    input  logic                  rst_n,
    input  logic                  update_valid,
    input  logic                  update_board,
    input  ppu_pkg::square_idx_t  update_square,
    input  ppu_pkg::square_rec_t  update_rec,
    input  logic                  turn,
    output logic                  update_ready,
    output logic [7:0]            r,
    output logic [7:0]            g,
    output logic [7:0]            b,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  blank_n
);

    ppu_pkg::coord_t x;
    ppu_pkg::coord_t y;
    logic            active;
    logic            vblank;
    logic            raw_hsync;
    logic            raw_vsync;
    logic            board_hit;
    ppu_pkg::pixel_t board_pixel;
    ppu_pkg::pixel_t back_pixel;

    vga_timing #(
        .h_total (h_total),
        .v_total (v_total)
    ) u_timing (
        .vga_clk   (vga_clk),
        .rst_n     (rst_n),
        .x         (x),
        .y         (y),
        .active    (active),
        .vblank    (vblank),
        .raw_hsync (raw_hsync),
        .raw_vsync (raw_vsync)
    );

    board_renderer u_board (
        .vga_clk       (vga_clk),
        .rst_n         (rst_n),
        .x             (x),
        .y             (y),
        .vblank        (vblank),
        .update_valid  (update_valid),
        .update_board  (update_board),
        .update_square (update_square),
        .update_rec    (update_rec),
        .update_ready  (update_ready),
        .board_hit     (board_hit),
        .board_pixel   (board_pixel)
    );

    backdrop_renderer u_backdrop (
        .vga_clk    (vga_clk),
        .rst_n      (rst_n),
        .x          (x),
        .y          (y),
        .vblank     (vblank),
        .turn       (turn),
        .back_pixel (back_pixel)
    );

    pixel_mixer u_mixer (
        .vga_clk     (vga_clk),
        .rst_n       (rst_n),
        .board_hit   (board_hit),
        .board_pixel (board_pixel),
        .back_pixel  (back_pixel),
        .active      (active),
        .raw_hsync   (raw_hsync),
        .raw_vsync   (raw_vsync),
        .r           (r),
        .g           (g),
        .b           (b),
        .hsync       (hsync),
        .vsync       (vsync),
        .blank_n     (blank_n)
    );

endmodule

// ==== source/vga_timing.sv ====
module vga_timing #(
    parameter ppu_pkg::coord_t h_total = ppu_pkg::h_total,
    parameter ppu_pkg::coord_t v_total = ppu_pkg::v_total
) (
    input  logic            vga_clk,
    input  logic            rst_n,
    output ppu_pkg::coord_t x,
    output ppu_pkg::coord_t y,
    output logic            active,
    output logic            vblank,
    output logic            raw_hsync,
    output logic            raw_vsync
);

    logic line_end;
    logic frame_end;

    assign line_end  = (x == h_total - 10'd1);
    assign frame_end = (y == v_total - 10'd1);

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            x <= '0;
            y <= '0;
        end else if (line_end) begin
            x <= '0;
            y <= frame_end ? '0 : y + 10'd1;
        end else begin
            x <= x + 10'd1;
        end
    end

    assign active = (x < ppu_pkg::h_active) && (y < ppu_pkg::v_active);
    assign vblank = (y >= ppu_pkg::v_active);

    // both syncs active low
    assign raw_hsync = !((x >= ppu_pkg::h_sync_start) && (x < ppu_pkg::h_sync_end));
    assign raw_vsync = !((y >= ppu_pkg::v_sync_start) && (y < ppu_pkg::v_sync_end));

    a_x_range: assert property (@(posedge vga_clk) disable iff (!rst_n)
        x < h_total);

endmodule
